/* dv/rob_testdata.txt */
// Block: n_instr n_ret stall / rd per instruction / CDB events (instr index, except, payload)
// Expected retirements in order: rd except value cause. A block with n_instr 0 ends the file
// In-order retirement, completions in reverse order
4 4 0
01 02 03 04
3 0 00000d04  2 0 00000c03  1 0 00000b02  0 0 00000a01
01 0 00000a01 00  02 0 00000b02 00  03 0 00000c03 00  04 0 00000d04 00
// Tag wrap, the fifth instruction waits for a free entry
5 5 0
05 06 07 08 09
0 0 11111111  2 0 33333333  1 0 22222222  3 0 44444444  4 0 55555555
05 0 11111111 00  06 0 22222222 00  07 0 33333333 00  08 0 44444444 00
09 0 55555555 00
// Random retire stalls
4 4 1
0a 0b 0c 0d
1 0 deadbeef  0 0 cafef00d  3 0 01234567  2 0 89abcdef
0a 0 cafef00d 00  0b 0 deadbeef 00  0c 0 89abcdef 00  0d 0 01234567 00
// Exception on the second instruction, two younger completed ones are flushed
4 2 0
11 12 13 14
2 0 00000333  3 0 00000444  0 0 00000111  1 1 0000000d
11 0 00000111 00  12 1 00000000 0d
// Recovery after the flush, tags restart at 0
3 3 1
1d 1e 1f
2 0 a5a5a5a5  0 0 5a5a5a5a  1 0 0f0f0f0f
1d 0 5a5a5a5a 00  1e 0 0f0f0f0f 00  1f 0 a5a5a5a5 00
// End of tests
0

/* build.f */
src/arch_pkg.sv
src/rob_pkg.sv
src/issue_unit.sv
src/rob.sv
src/commit_unit.sv
src/rob_top.sv
dv/tb_rob_top.sv

/* Makefile */
# Verilator flow for the ROB subsystem testbench
SRCS := $(shell cat build.f)

.PHONY: run clean

run: obj_dir/Vtb_rob_top
	@./obj_dir/Vtb_rob_top > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@! grep -q "Test failed" sim.log

obj_dir/Vtb_rob_top: build.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_rob_top -f build.f -o Vtb_rob_top

clean:
	rm -rf obj_dir sim.log

/* dv/tb_rob_top.sv */
// --------------------
// ROB subsystem testbench
// Replays test blocks from the data file, plays the execution
// units on the CDB and checks every retirement in program order
// --------------------
`timescale 1ns/100ps

module tb_rob_top
  import arch_pkg::*;
  import rob_pkg::*;
();

  localparam int          CLK_PERIOD       = 4;
  localparam int unsigned SEED             = 32'h8deb3475;
  localparam int          CYCLES_PER_INSTR = 50;
  localparam int          MAX_INSTR        = 16;
  localparam int          TD_WORDS         = 256;
  localparam string       DATA_FILE        = "dv/rob_testdata.txt";

  // DUT ports
  logic                 clk_i;
  logic                 rst_ni;
  logic                 in_valid_i;
  logic                 in_ready_o;
  logic [REG_IDX_W-1:0] in_rd_i;
  logic                 tag_valid_o;
  logic [ROB_TAG_W-1:0] tag_o;
  logic [REG_IDX_W-1:0] tag_rd_o;
  logic                 cdb_valid_i;
  logic [ROB_TAG_W-1:0] cdb_tag_i;
  logic                 cdb_except_i;
  result_payload_u      cdb_payload_i;
  logic                 ret_valid_o;
  logic                 ret_ready_i;
  logic [REG_IDX_W-1:0] ret_rd_o;
  logic [XLEN-1:0]      ret_value_o;
  logic                 ret_except_o;
  logic [CAUSE_W-1:0]   ret_cause_o;

  // --------------------
  // Test state
  // --------------------
  logic [31:0]          td        [TD_WORDS];
  logic [REG_IDX_W-1:0] instr_rd  [MAX_INSTR];
  logic [ROB_TAG_W-1:0] tag_of    [MAX_INSTR];
  logic [REG_IDX_W-1:0] exp_rd    [MAX_INSTR];
  logic                 exp_exc   [MAX_INSTR];
  logic [XLEN-1:0]      exp_val   [MAX_INSTR];
  logic [CAUSE_W-1:0]   exp_cause [MAX_INSTR];
  int                   rd_ptr;
  int                   n_ret;
  int                   tag_cnt;
  int                   ret_cnt;
  int                   stall;
  int                   err_cnt;
  int                   test_cnt;
  int                   cycles;
  int                   cycle_limit;
  // Next tag the ROB should hand out
  logic [ROB_TAG_W-1:0] exp_tag;
  // Retire record seen under a stall
  logic                                held;
  logic [REG_IDX_W+XLEN+CAUSE_W:0]     held_rec;
  logic [REG_IDX_W+XLEN+CAUSE_W:0]     ret_rec;

  assign ret_rec = {ret_rd_o, ret_except_o, ret_value_o, ret_cause_o};

  rob_top i_rob_top (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // --------------------
  // Monitor
  // --------------------
  // Sampled mid cycle with the retire side first so a flush resets tags before new ones
  always @(negedge clk_i) begin : p_monitor
    if (rst_ni) begin
      if (held && (!ret_valid_o || ret_rec != held_rec)) begin
        $display("%0t ns: retire record changed while ret_ready_i was low", $time);
        err_cnt++;
      end
      held     = ret_valid_o && !ret_ready_i;
      held_rec = ret_rec;
      if (ret_valid_o && ret_ready_i) begin
        if (ret_cnt >= n_ret) begin
          $display("%0t ns: unexpected retirement of rd %0d", $time, ret_rd_o);
          err_cnt++;
        end else begin
          check_eq("ret_rd_o", 32'(ret_rd_o), 32'(exp_rd[ret_cnt]));
          check_eq("ret_except_o", 32'(ret_except_o), 32'(exp_exc[ret_cnt]));
          check_eq("ret_value_o", ret_value_o, exp_val[ret_cnt]);
          check_eq("ret_cause_o", 32'(ret_cause_o), 32'(exp_cause[ret_cnt]));
          // Flush restarts allocation at entry 0
          if (exp_exc[ret_cnt]) begin
            exp_tag = '0;
          end
        end
        ret_cnt++;
      end
      if (tag_valid_o) begin
        if (tag_cnt < MAX_INSTR) begin
          check_eq("tag_o", 32'(tag_o), 32'(exp_tag));
          check_eq("tag_rd_o", 32'(tag_rd_o), 32'(instr_rd[tag_cnt]));
          tag_of[tag_cnt] = tag_o;
        end
        tag_cnt++;
        exp_tag = ROB_TAG_W'((int'(exp_tag) + 1) % int'(ROB_DEPTH));
        // Full ROB plus a stalled retire slot
        if (tag_cnt - ret_cnt > int'(ROB_DEPTH) + stall) begin
          $display("%0t ns: tag handed out while all ROB entries were in use", $time);
          err_cnt++;
        end
      end
    end
  end

  // Retire port back-pressure
  always @(posedge clk_i) begin : p_ret_ready
    #1;
    ret_ready_i = (stall == 0) || ($urandom % 3 != 0);
  end

  always @(posedge clk_i) begin : p_timeout
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Run stopped after %0d cycles, the DUT made no further progress", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic issue_all(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      #1;
      in_valid_i = 1'b1;
      in_rd_i    = instr_rd[i];
      @(negedge clk_i);
      while (!in_ready_o) @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    in_valid_i = 1'b0;
  endtask

  // Execution units write one CDB result per cycle once the tag is known
  task automatic drive_cdb(input int base, input int n);
    int          idx;
    logic [31:0] word;
    for (int e = 0; e < n; e++) begin
      idx  = int'(td[base + 3 * e]);
      word = td[base + 3 * e + 2];
      do begin
        @(posedge clk_i);
        #1;
        cdb_valid_i = 1'b0;
      end while (tag_cnt <= idx);
      cdb_valid_i  = 1'b1;
      cdb_tag_i    = tag_of[idx];
      cdb_except_i = td[base + 3 * e + 1][0];
      if (cdb_except_i) begin
        cdb_payload_i.cause = word;
      end else begin
        cdb_payload_i.value = word;
      end
    end
    @(posedge clk_i);
    #1;
    cdb_valid_i = 1'b0;
  endtask

  task automatic run_block();
    int n;
    int cdb_base;
    int errs_before;
    n     = int'(td[rd_ptr]);
    n_ret = int'(td[rd_ptr + 1]);
    stall = int'(td[rd_ptr + 2]);
    rd_ptr += 3;
    for (int i = 0; i < n; i++) begin
      instr_rd[i] = td[rd_ptr + i][REG_IDX_W-1:0];
    end
    cdb_base = rd_ptr + n;
    rd_ptr   = cdb_base + 3 * n;
    for (int i = 0; i < n_ret; i++) begin
      exp_rd[i]    = td[rd_ptr][REG_IDX_W-1:0];
      exp_exc[i]   = td[rd_ptr + 1][0];
      exp_val[i]   = td[rd_ptr + 2];
      exp_cause[i] = td[rd_ptr + 3][CAUSE_W-1:0];
      rd_ptr += 4;
    end
    tag_cnt     = 0;
    ret_cnt     = 0;
    errs_before = err_cnt;
    fork
      issue_all(n);
      drive_cdb(cdb_base, n);
    join
    while (ret_cnt < n_ret) @(posedge clk_i);
    // Quiet period in which flushed or repeated records would show up
    repeat (ROB_DEPTH + 4) @(posedge clk_i);
    check_eq("tags handed out", tag_cnt, n);
    test_cnt++;
    $display("test %0d: %0d instructions, %0d retirements, %0d errors",
             test_cnt, n, ret_cnt, err_cnt - errs_before);
  endtask

  initial begin : p_main
    int q;
    int total_instr;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    in_valid_i    = 1'b0;
    in_rd_i       = '0;
    cdb_valid_i   = 1'b0;
    cdb_tag_i     = '0;
    cdb_except_i  = 1'b0;
    cdb_payload_i = '0;
    ret_ready_i   = 1'b1;
    n_ret         = 0;
    tag_cnt       = 0;
    ret_cnt       = 0;
    stall         = 0;
    err_cnt       = 0;
    test_cnt      = 0;
    cycles        = 0;
    exp_tag       = '0;
    held          = 1'b0;
    void'($urandom(SEED));
    $readmemh(DATA_FILE, td);
    // Timeout scales with the instruction count of the file
    q           = 0;
    total_instr = 0;
    while (q < TD_WORDS - 3 && td[q] != 32'h0) begin
      total_instr += int'(td[q]);
      q += 3 + 4 * int'(td[q]) + 4 * int'(td[q + 1]);
    end
    cycle_limit = CYCLES_PER_INSTR * total_instr;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Idle outputs out of reset
    @(negedge clk_i);
    check_eq("in_ready_o", 32'(in_ready_o), 32'd1);
    check_eq("ret_valid_o", 32'(ret_valid_o), 32'd0);
    check_eq("tag_valid_o", 32'(tag_valid_o), 32'd0);
    @(posedge clk_i);
    rd_ptr = 0;
    while (rd_ptr < TD_WORDS - 3 && td[rd_ptr] != 32'h0) begin
      run_block();
    end
    if (test_cnt == 0) begin
      $display("No test blocks could be read from %s", DATA_FILE);
      err_cnt++;
    end
    $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* src/rob_top.sv */
// --------------------
// ROB subsystem top
// Issue unit, reorder buffer and commit unit with a shared flush
// --------------------
`timescale 1ns/100ps

module rob_top
  import arch_pkg::*;
  import rob_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Instruction input
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [REG_IDX_W-1:0] in_rd_i,
  // Allocated tag report
  output logic                 tag_valid_o,
  output logic [ROB_TAG_W-1:0] tag_o,
  output logic [REG_IDX_W-1:0] tag_rd_o,
  // Common data bus
  input  logic                 cdb_valid_i,
  input  logic [ROB_TAG_W-1:0] cdb_tag_i,
  input  logic                 cdb_except_i,
  input  result_payload_u      cdb_payload_i,
  // Retirement port
  output logic                 ret_valid_o,
  input  logic                 ret_ready_i,
  output logic [REG_IDX_W-1:0] ret_rd_o,
  output logic [XLEN-1:0]      ret_value_o,
  output logic                 ret_except_o,
  output logic [CAUSE_W-1:0]   ret_cause_o
);

  // Issue to ROB
  logic                 iss_valid;
  logic                 iss_ready;
  logic [REG_IDX_W-1:0] iss_rd;
  logic [ROB_TAG_W-1:0] iss_tag;
  // ROB head to commit
  logic                 head_valid;
  logic                 head_ready;
  logic [REG_IDX_W-1:0] head_rd;
  logic                 head_except;
  result_payload_u      head_payload;
  // Exception recovery
  logic                 flush;

  // Producer
  issue_unit u_issue (
    .flush_i    (flush),
    .iss_valid_o(iss_valid),
    .iss_ready_i(iss_ready),
    .iss_rd_o   (iss_rd),
    .iss_tag_i  (iss_tag),
    .*
  );

  // Buffer
  rob u_rob (
    .flush_i       (flush),
    .iss_valid_i   (iss_valid),
    .iss_ready_o   (iss_ready),
    .iss_rd_i      (iss_rd),
    .iss_tag_o     (iss_tag),
    .head_valid_o  (head_valid),
    .head_ready_i  (head_ready),
    .head_rd_o     (head_rd),
    .head_except_o (head_except),
    .head_payload_o(head_payload),
    .*
  );

  // Consumer, its flush feeds both upstream blocks
  commit_unit u_commit (
    .head_valid_i  (head_valid),
    .head_ready_o  (head_ready),
    .head_rd_i     (head_rd),
    .head_except_i (head_except),
    .head_payload_i(head_payload),
    .flush_o       (flush),
    .*
  );

endmodule

/* src/commit_unit.sv */
// --------------------
// Commit unit
// One-record retire slot that decodes the result payload and
// raises a flush when an excepting entry is retired
// --------------------
`timescale 1ns/100ps

module commit_unit
  import arch_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Head entry from the ROB
  input  logic                 head_valid_i,
  output logic                 head_ready_o,
  input  logic [REG_IDX_W-1:0] head_rd_i,
  input  logic                 head_except_i,
  input  result_payload_u      head_payload_i,
  // Retirement port
  output logic                 ret_valid_o,
  input  logic                 ret_ready_i,
  output logic [REG_IDX_W-1:0] ret_rd_o,
  output logic [XLEN-1:0]      ret_value_o,
  output logic                 ret_except_o,
  output logic [CAUSE_W-1:0]   ret_cause_o,
  // Pipeline flush
  output logic                 flush_o
);

  // Retire slot
  logic                 vld_q;
  logic [REG_IDX_W-1:0] rd_q;
  logic                 except_q;
  result_payload_u      payload_q;
  // Flush pulse
  logic                 flush_q;
  // Handshakes
  logic                 take;
  logic                 drain;

  assign drain = vld_q && ret_ready_i;
  // Slot free or emptying, and younger entries are held off while flushing
  assign head_ready_o = (!vld_q || ret_ready_i) && !flush_q;
  assign take = head_valid_i && head_ready_o;

  // --------------------
  // Slot control
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      vld_q   <= 1'b0;
      flush_q <= 1'b0;
    end else begin
      if (take) begin
        vld_q <= 1'b1;
      end else if (drain) begin
        vld_q <= 1'b0;
      end
      // Exception flushes the cycle after it enters the slot
      flush_q <= take && head_except_i;
    end
  end

  always_ff @(posedge clk_i) begin : p_data
    if (take) begin
      rd_q      <= head_rd_i;
      except_q  <= head_except_i;
      payload_q <= head_payload_i;
    end
  end

  // --------------------
  // Payload decode
  // --------------------
  // Value view on a normal entry, cause view on an excepting one
  assign ret_valid_o  = vld_q;
  assign ret_rd_o     = rd_q;
  assign ret_except_o = except_q;
  assign ret_value_o  = except_q ? '0 : payload_q.value;
  assign ret_cause_o  = except_q ? payload_q.cause[CAUSE_W-1:0] : '0;
  assign flush_o      = flush_q;

  // One flush per exception
  a_flush_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_o |=> !flush_o);

endmodule

/* src/rob.sv */
// --------------------
// Reorder buffer
// Circular entry array, allocated at the tail in program order,
// filled by tag from the CDB and popped at the head in order
// --------------------
`timescale 1ns/100ps

module rob
  import arch_pkg::*;
  import rob_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Allocation from the issue unit
  input  logic                 iss_valid_i,
  output logic                 iss_ready_o,
  input  logic [REG_IDX_W-1:0] iss_rd_i,
  output logic [ROB_TAG_W-1:0] iss_tag_o,
  // Common data bus
  input  logic                 cdb_valid_i,
  input  logic [ROB_TAG_W-1:0] cdb_tag_i,
  input  logic                 cdb_except_i,
  input  result_payload_u      cdb_payload_i,
  // Head entry to the commit unit
  output logic                 head_valid_o,
  input  logic                 head_ready_i,
  output logic [REG_IDX_W-1:0] head_rd_o,
  output logic                 head_except_o,
  output result_payload_u      head_payload_o
);

  // --------------------
  // Entry state
  // --------------------
  // Entry holds an instruction
  logic [ROB_DEPTH-1:0] alloc_q;
  // Result has arrived
  logic [ROB_DEPTH-1:0] done_q;
  // Per entry payload
  logic [REG_IDX_W-1:0] rd_q      [ROB_DEPTH];
  logic                 except_q  [ROB_DEPTH];
  result_payload_u      payload_q [ROB_DEPTH];

  // Oldest entry and first free entry
  logic [ROB_TAG_W-1:0] head_q;
  logic [ROB_TAG_W-1:0] tail_q;

  logic push;
  logic pop;

  // Mod ROB_DEPTH increment
  function automatic logic [ROB_TAG_W-1:0] next_idx(input logic [ROB_TAG_W-1:0] idx);
    if (idx == ROB_TAG_W'(ROB_DEPTH - 1)) begin
      return '0;
    end
    return idx + ROB_TAG_W'(1);
  endfunction

  assign push = iss_valid_i && iss_ready_o;
  assign pop  = head_valid_o && head_ready_i;

  // --------------------
  // Control update
  // --------------------
  // Per entry priority is push, pop, then CDB
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      alloc_q <= '0;
      done_q  <= '0;
      head_q  <= '0;
      tail_q  <= '0;
    end else if (flush_i) begin
      // Dropping the allocated bits empties the buffer
      alloc_q <= '0;
      head_q  <= '0;
      tail_q  <= '0;
    end else begin
      for (int i = 0; i < ROB_DEPTH; i++) begin
        if (push && tail_q == ROB_TAG_W'(i)) begin
          alloc_q[i] <= 1'b1;
          done_q[i]  <= 1'b0;
        end else if (pop && head_q == ROB_TAG_W'(i)) begin
          alloc_q[i] <= 1'b0;
        end else if (cdb_valid_i && cdb_tag_i == ROB_TAG_W'(i)) begin
          done_q[i] <= 1'b1;
        end
      end
      if (push) begin
        tail_q <= next_idx(tail_q);
      end
      if (pop) begin
        head_q <= next_idx(head_q);
      end
    end
  end

  // --------------------
  // Payload update
  // --------------------
  always_ff @(posedge clk_i) begin : p_data
    for (int i = 0; i < ROB_DEPTH; i++) begin
      // Destination known at issue
      if (push && tail_q == ROB_TAG_W'(i)) begin
        rd_q[i] <= iss_rd_i;
      end
      // Result or cause from the CDB
      if (cdb_valid_i && cdb_tag_i == ROB_TAG_W'(i)) begin
        except_q[i]  <= cdb_except_i;
        payload_q[i] <= cdb_payload_i;
      end
    end
  end

  // --------------------
  // Outputs
  // --------------------
  // Full when the tail wraps onto a live entry
  assign iss_ready_o = !alloc_q[tail_q] && !flush_i;
  assign iss_tag_o   = tail_q;

  // Head ready to retire once its result is in
  assign head_valid_o   = alloc_q[head_q] && done_q[head_q];
  assign head_rd_o      = rd_q[head_q];
  assign head_except_o  = except_q[head_q];
  assign head_payload_o = payload_q[head_q];

  // --------------------
  // Assertions
  // --------------------
  // Execution units only complete issued instructions
  a_cdb_alloc : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cdb_valid_i && !flush_i |-> alloc_q[cdb_tag_i]);

  // Never allocate and retire the same slot at once
  a_push_pop_idx : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push && pop |-> head_q != tail_q);

  // Head offer is not withdrawn under back-pressure
  a_head_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    head_valid_o && !head_ready_i && !flush_i |=> head_valid_o);

endmodule

/* src/issue_unit.sv */
// --------------------
// Issue unit
// One-entry stage that takes instructions in program order,
// hands them to the ROB and reports the allocated tag
// --------------------
`timescale 1ns/100ps

module issue_unit
  import arch_pkg::*;
  import rob_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Instruction input
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [REG_IDX_W-1:0] in_rd_i,
  // ROB allocation
  output logic                 iss_valid_o,
  input  logic                 iss_ready_i,
  output logic [REG_IDX_W-1:0] iss_rd_o,
  input  logic [ROB_TAG_W-1:0] iss_tag_i,
  // Allocated tag report
  output logic                 tag_valid_o,
  output logic [ROB_TAG_W-1:0] tag_o,
  output logic [REG_IDX_W-1:0] tag_rd_o
);

  // Held instruction
  logic                 vld_q;
  logic [REG_IDX_W-1:0] rd_q;
  // Tag report registers
  logic                 tag_valid_q;
  logic [ROB_TAG_W-1:0] tag_q;
  logic [REG_IDX_W-1:0] tag_rd_q;
  // Handshakes
  logic                 in_fire;
  logic                 iss_fire;

  assign iss_fire = vld_q && iss_ready_i;
  // Empty or leaving this cycle, nothing enters during a flush
  assign in_ready_o = (!vld_q || iss_ready_i) && !flush_i;
  assign in_fire = in_valid_i && in_ready_o;

  // --------------------
  // Stage control
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      vld_q       <= 1'b0;
      tag_valid_q <= 1'b0;
    end else begin
      if (flush_i) begin
        vld_q <= 1'b0;
      end else if (in_fire) begin
        vld_q <= 1'b1;
      end else if (iss_fire) begin
        vld_q <= 1'b0;
      end
      // One-cycle pulse per allocation
      tag_valid_q <= iss_fire && !flush_i;
    end
  end

  // Payload of the stage and of the tag report
  always_ff @(posedge clk_i) begin : p_data
    if (in_fire) begin
      rd_q <= in_rd_i;
    end
    if (iss_fire) begin
      tag_q    <= iss_tag_i;
      tag_rd_q <= rd_q;
    end
  end

  assign iss_valid_o = vld_q;
  assign iss_rd_o    = rd_q;
  assign tag_valid_o = tag_valid_q;
  assign tag_o       = tag_q;
  assign tag_rd_o    = tag_rd_q;

  // Held instruction waits unchanged for room in the ROB
  a_hold_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    iss_valid_o && !iss_ready_i && !flush_i |=> iss_valid_o && $stable(iss_rd_o));

endmodule

/* src/rob_pkg.sv */
// --------------------
// ROB package
// Buffer sizing and tag width
// --------------------
package rob_pkg;

  // Number of entries in flight
  localparam int unsigned ROB_DEPTH = 4;

  // Tag is the entry index
  localparam int unsigned ROB_TAG_W = $clog2(ROB_DEPTH);

endpackage

/* src/arch_pkg.sv */
// --------------------
// Architecture package
// Data widths and the result payload seen by issue, ROB and commit
// --------------------
package arch_pkg;

  // --------------------
  // Widths
  // --------------------
  // Result value
  localparam int unsigned XLEN = 32;
  // Destination register index
  localparam int unsigned REG_IDX_W = 5;
  // Exception cause code
  localparam int unsigned CAUSE_W = 5;

  // --------------------
  // Result payload
  // --------------------
  // One word from an execution unit
  // The except flag travelling beside it selects the view
  typedef union packed {
    // Normal result value
    logic [XLEN-1:0] value;
    // Exception word with the cause in its low CAUSE_W bits
    logic [XLEN-1:0] cause;
  } result_payload_u;

endpackage
